// File: rtl/snd_pkg.sv
// ==========================================================
// Widths and types shared by the audio DAC path
// Input samples are 16-bit PCM levels in the clk_dac domain
// ==========================================================
package snd_pkg;

    // One PCM sample as the core delivers it
    localparam int PCM_W = 16;

    // Modulator word: zero guard bit, 16 sample bits, zero pad bits
    localparam int ACC_W = 20;

    // Low zero bits below the sample in the modulator word
    localparam int PAD_W = ACC_W - PCM_W - 1;

    // Feedback level for a one on the pin, 2^19
    localparam int FULL_SCALE = 1 << (ACC_W - 1);

    // First integrator swings about +-1.5 full scale
    localparam int INT1_W = ACC_W + 4;

    // Second integrator grows as 1/(1-x) near the rails,
    // peaks near 2^33 with the half-LSB input offset
    localparam int INT2_W = ACC_W + 18;

    // Supported clock-enable periods in clk_dac cycles
    localparam int DIV_MIN = 2;
    localparam int DIV_MAX = 16;

    typedef logic [PCM_W-1:0] pcm_t;

    typedef logic [ACC_W-1:0] acc_t;

    // Integrator states, two's complement
    typedef logic signed [INT1_W-1:0] int1_t;
    typedef logic signed [INT2_W-1:0] int2_t;

endpackage

// File: rtl/snd_cen_gen.sv
// ==========================================================
// DIV must be 2..16; first enable lands DIV cycles after reset
// ==========================================================
`timescale 1ns/1ps

module snd_cen_gen #(
    parameter int DIV = 4
) (
    input  logic clk_dac,
    input  logic rst,
    output logic cen_o
);

    // Single one rotating right, enable taken from bit 0
    logic [DIV-1:0] ring_q;

    if (DIV < snd_pkg::DIV_MIN || DIV > snd_pkg::DIV_MAX) begin : g_div_check
        $error("snd_cen_gen: DIV must lie between 2 and 16");
    end

    // Reset loads the top bit, so bit 0 is reached after DIV-1 shifts
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring_q <= {1'b1, {(DIV - 1){1'b0}}};
        end else begin
            ring_q <= {ring_q[0], ring_q[DIV-1:1]};
        end
    end

    assign cen_o = ring_q[0];

    // A lost or doubled token would change the modulator rate
    a_ring_onehot: assert property (
        @(posedge clk_dac) disable iff (rst)
        $onehot(ring_q)
    ) else $error("snd_cen_gen: ring lost its one-hot state");

endmodule

// File: rtl/snd_pcm_cond.sv
// ==========================================================
// Sample is captured only on cen_i; one enable of latency
// SIGNED_SND=1 expects two's complement, 0 offset binary
// ==========================================================
`timescale 1ns/1ps

module snd_pcm_cond #(
    parameter bit SIGNED_SND = 1'b1
) (
    input  logic          clk_dac,
    input  logic          rst,
    input  logic          cen_i,
    input  snd_pkg::pcm_t pcm_i,
    output snd_pkg::acc_t acc_o
);

    // Flips the sign bit to reach offset binary
    localparam snd_pkg::pcm_t SIGN_MASK = {SIGNED_SND, {(snd_pkg::PCM_W - 1){1'b0}}};

    snd_pkg::pcm_t pcm_ob;
    snd_pkg::acc_t acc_q;

    // Offset-binary view of the incoming level
    assign pcm_ob = pcm_i ^ SIGN_MASK;

    // Guard bit on top keeps the word below the 2^19 feedback level,
    // pad bits below scale one sample LSB to eight modulator units
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
        end else if (cen_i) begin
            acc_q <= {1'b0, pcm_ob, {snd_pkg::PAD_W{1'b0}}};
        end
    end

    assign acc_o = acc_q;

    // Guard bit clear, so the input stays below full scale
    a_guard_zero: assert property (
        @(posedge clk_dac) disable iff (rst)
        acc_o[snd_pkg::ACC_W-1] == 1'b0
    ) else $error("snd_pcm_cond: guard bit set in modulator word");

endmodule

// File: rtl/snd_sigma_delta.sv
// ==========================================================
// Pin density is (U+0.5)/65536 for offset-binary sample U
// Output bit is registered and changes only after cen_i
// ==========================================================
`timescale 1ns/1ps

module snd_sigma_delta (
    input  logic          clk_dac,
    input  logic          rst,
    input  logic          cen_i,
    input  snd_pkg::acc_t acc_i,
    output logic          pwm_o
);

    localparam int I1_W  = snd_pkg::INT1_W;
    localparam int I2_W  = snd_pkg::INT2_W;
    localparam int SUM_W = I2_W + 2;

    // Half a sample LSB; keeps the input off both feedback levels
    localparam int HALF_LSB = 1 << (snd_pkg::PAD_W - 1);

    typedef logic signed [SUM_W-1:0] sum_t;

    localparam sum_t FB_HI  = sum_t'(snd_pkg::FULL_SCALE);
    localparam sum_t I1_MAX = (sum_t'(1) <<< (I1_W - 1)) - sum_t'(1);
    localparam sum_t I1_MIN = -(sum_t'(1) <<< (I1_W - 1));
    localparam sum_t I2_MAX = (sum_t'(1) <<< (I2_W - 1)) - sum_t'(1);
    localparam sum_t I2_MIN = -(sum_t'(1) <<< (I2_W - 1));

    snd_pkg::int1_t i1_q;
    snd_pkg::int1_t i1_nxt;
    snd_pkg::int2_t i2_q;
    snd_pkg::int2_t i2_nxt;
    logic           pwm_q;

    sum_t x_w;
    sum_t fb_w;
    sum_t i1_sum;
    sum_t i1_sat;
    sum_t i2_sum;
    sum_t i2_sat;
    logic i1_clip;
    logic i2_clip;

    // Limit a wide sum to an integrator range
    function automatic sum_t clamp(input sum_t v, input sum_t lo, input sum_t hi);
        sum_t r;
        if (v > hi) begin
            r = hi;
        end else if (v < lo) begin
            r = lo;
        end else begin
            r = v;
        end
        return r;
    endfunction

    // Both integrators subtract the feedback chosen by the last bit,
    // the second one adds the freshly updated first integrator.
    // Gives NTF (1-z^-1)^2 with a one-sample signal delay
    always_comb begin
        x_w    = sum_t'(acc_i) + sum_t'(HALF_LSB);
        fb_w   = pwm_q ? FB_HI : '0;

        i1_sum = sum_t'(i1_q) + x_w - fb_w;
        i1_sat = clamp(i1_sum, I1_MIN, I1_MAX);
        i1_nxt = i1_sat[I1_W-1:0];

        i2_sum = sum_t'(i2_q) + sum_t'(i1_nxt) - fb_w;
        i2_sat = clamp(i2_sum, I2_MIN, I2_MAX);
        i2_nxt = i2_sat[I2_W-1:0];

        i1_clip = (i1_sat != i1_sum);
        i2_clip = (i2_sat != i2_sum);
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            i1_q  <= '0;
            i2_q  <= '0;
            pwm_q <= 1'b0;
        end else if (cen_i) begin
            i1_q  <= i1_nxt;
            i2_q  <= i2_nxt;
            // Non-negative second integrator gives a one
            pwm_q <= ~i2_nxt[I2_W-1];
        end
    end

    assign pwm_o = pwm_q;

    // Clamping only guards against overflow wrap; any input level,
    // including jumps between the rails, must stay inside the range
    a_no_clip: assert property (
        @(posedge clk_dac) disable iff (rst)
        cen_i |-> !(i1_clip || i2_clip)
    ) else $error("snd_sigma_delta: integrator reached its limit");

endmodule

// File: rtl/snd_dac_top.sv
// ==========================================================
// STEREO=0 ignores snd_right_i; right pin mirrors left pin
// Pins need an external RC low-pass filter
// ==========================================================
`timescale 1ns/1ps

module snd_dac_top #(
    parameter bit SIGNED_SND = 1'b1,
    parameter bit STEREO     = 1'b1,
    parameter int DIV        = 4
) (
    input  logic          clk_dac,
    input  logic          rst,
    input  snd_pkg::pcm_t snd_left_i,
    input  snd_pkg::pcm_t snd_right_i,
    output logic          snd_pwm_left_o,
    output logic          snd_pwm_right_o
);

    // Modulator rate strobe, shared by all stages
    logic          cen;
    snd_pkg::acc_t acc_left;

    snd_cen_gen #(
        .DIV        ( DIV        )
    ) u_cen (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .cen_o      ( cen        )
    );

    // Left channel
    snd_pcm_cond #(
        .SIGNED_SND ( SIGNED_SND )
    ) u_cond_left (
        .clk_dac    ( clk_dac    ),
        .rst        ( rst        ),
        .cen_i      ( cen        ),
        .pcm_i      ( snd_left_i ),
        .acc_o      ( acc_left   )
    );

    snd_sigma_delta u_dac_left (
        .clk_dac    ( clk_dac        ),
        .rst        ( rst            ),
        .cen_i      ( cen            ),
        .acc_i      ( acc_left       ),
        .pwm_o      ( snd_pwm_left_o )
    );

    // Right channel only for stereo builds
    if (STEREO) begin : g_stereo
        snd_pkg::acc_t acc_right;

        snd_pcm_cond #(
            .SIGNED_SND ( SIGNED_SND  )
        ) u_cond_right (
            .clk_dac    ( clk_dac     ),
            .rst        ( rst         ),
            .cen_i      ( cen         ),
            .pcm_i      ( snd_right_i ),
            .acc_o      ( acc_right   )
        );

        snd_sigma_delta u_dac_right (
            .clk_dac    ( clk_dac         ),
            .rst        ( rst             ),
            .cen_i      ( cen             ),
            .acc_i      ( acc_right       ),
            .pwm_o      ( snd_pwm_right_o )
        );
    end else begin : g_mono
        assign snd_pwm_right_o = snd_pwm_left_o;
    end

endmodule

// File: bench/tb_snd_tasks.svh
// ============================================================
// Tasks start and return 1 ns after a rising clk_dac edge
// Expected densities follow U/65536 for offset-binary level U
// ============================================================

// Next random level from the upper half of the LCG state
function automatic snd_pkg::pcm_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
endfunction

// Two's complement sample to its offset-binary level, 0..65535
function automatic int offset_level(input snd_pkg::pcm_t s);
    snd_pkg::pcm_t u;
    u = {~s[snd_pkg::PCM_W-1], s[snd_pkg::PCM_W-2:0]};
    return int'(u);
endfunction

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_dac);
    #1;
endtask

task automatic check_bit(input logic exp, input logic act, input string what);
    if (act !== exp) begin
        $display("Mismatch at %0t ns: %s expected %b got %b", $time, what, exp, act);
        error_count++;
    end
endtask

task automatic check_density(input real meas, input real exp, input string what);
    real diff;
    diff = meas - exp;
    if (diff < 0.0) begin
        diff = -diff;
    end
    if (diff > TOL) begin
        $display("Mismatch at %0t ns: %s density %f expected %f", $time, what, meas, exp);
        error_count++;
    end
endtask

task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
        $display("%s: ok", name);
    end else begin
        failed_tests++;
        $display("%s: FAILED with %0d errors", name, error_count - errs_before);
    end
endtask

// Inputs are set before release so the first enable captures them
task automatic apply_reset(input snd_pkg::pcm_t left, input snd_pkg::pcm_t right);
    snd_left  = left;
    snd_right = right;
    rst       = 1'b1;
    wait_cycles(RST_CYC);
    rst       = 1'b0;
endtask

// One sample per modulator period, so every output bit is seen once
task automatic measure_pins(output int ones_l, output int ones_r, output int run_l);
    logic prev_l;
    int   run;
    ones_l = 0;
    ones_r = 0;
    wait_cycles(SETTLE * DIV);
    prev_l = pwm_left;
    run    = 1;
    run_l  = 1;
    for (int i = 0; i < MEASURE; i++) begin
        wait_cycles(DIV);
        run    = (pwm_left === prev_l) ? run + 1 : 1;
        prev_l = pwm_left;
        if (run > run_l) begin
            run_l = run;
        end
        ones_l += (pwm_left === 1'b1) ? 1 : 0;
        ones_r += (pwm_right === 1'b1) ? 1 : 0;
    end
endtask

task automatic run_density(input snd_pkg::pcm_t left, input snd_pkg::pcm_t right,
                           input string what, output int run_l);
    int ones_l;
    int ones_r;
    apply_reset(left, right);
    measure_pins(ones_l, ones_r, run_l);
    check_density(real'(ones_l) / real'(MEASURE), real'(offset_level(left)) / 65536.0,
                  {what, " left"});
    check_density(real'(ones_r) / real'(MEASURE), real'(offset_level(right)) / 65536.0,
                  {what, " right"});
endtask

task automatic test_reset_low();
    int errs;
    errs      = error_count;
    snd_left  = 16'h7FFF;
    snd_right = 16'h7FFF;
    rst       = 1'b1;
    for (int i = 0; i < RST_CYC; i++) begin
        wait_cycles(1);
        check_bit(1'b0, pwm_left, "left pin in reset");
        check_bit(1'b0, pwm_right, "right pin in reset");
    end
    rst = 1'b0;
    // First enable is only taken DIV cycles after release
    for (int i = 1; i < DIV; i++) begin
        wait_cycles(1);
        check_bit(1'b0, pwm_left, "left pin before first enable");
        check_bit(1'b0, pwm_right, "right pin before first enable");
    end
    finish_test("reset_low", errs);
endtask

task automatic test_extremes();
    int errs;
    int run_l;
    errs = error_count;
    run_density(16'h8000, 16'h8000, "negative full scale", run_l);
    run_density(16'h7FFF, 16'h7FFF, "positive full scale", run_l);
    finish_test("extremes", errs);
endtask

task automatic test_midscale();
    int errs;
    int run_l;
    errs = error_count;
    run_density(16'h0000, 16'h0000, "midscale", run_l);
    if (run_l > MAX_RUN) begin
        $display("Midscale pattern held one level for %0d periods, more than %0d allowed",
                 run_l, MAX_RUN);
        error_count++;
    end
    finish_test("midscale", errs);
endtask

task automatic test_random_levels();
    int            errs;
    int            run_l;
    snd_pkg::pcm_t left;
    snd_pkg::pcm_t right;
    errs = error_count;
    for (int i = 0; i < 8; i++) begin
        left  = lcg_next();
        right = lcg_next();
        run_density(left, right, $sformatf("level %0d (%h/%h)", i, left, right), run_l);
    end
    finish_test("random_levels", errs);
endtask

// Levels far apart, 7/8 on the left and 1/8 on the right
task automatic test_stereo();
    int errs;
    int run_l;
    errs = error_count;
    run_density(16'h6000, 16'hA000, "stereo split", run_l);
    finish_test("stereo", errs);
endtask

task automatic track_edge(input logic now, input int c, input string pin,
                          inout logic prev, inout int last, inout int edges);
    if (now !== prev) begin
        if (last >= 0 && (c - last) % DIV != 0) begin
            $display("Mismatch at %0t ns: %s pin changed %0d cycles after its last change",
                     $time, pin, c - last);
            error_count++;
        end
        last = c;
        edges++;
    end
    prev = now;
endtask

task automatic test_transition_spacing();
    int   errs;
    int   last_l;
    int   last_r;
    int   edges_l;
    int   edges_r;
    logic prev_l;
    logic prev_r;
    errs = error_count;
    apply_reset(16'h0000, 16'hC000);
    wait_cycles(16 * DIV);
    prev_l  = pwm_left;
    prev_r  = pwm_right;
    last_l  = -1;
    last_r  = -1;
    edges_l = 0;
    edges_r = 0;
    for (int c = 0; c < SPAN_CYC; c++) begin
        wait_cycles(1);
        track_edge(pwm_left, c, "left", prev_l, last_l, edges_l);
        track_edge(pwm_right, c, "right", prev_r, last_r, edges_r);
    end
    if (edges_l < 16 || edges_r < 16) begin
        $display("Too few pin transitions to check spacing: left %0d, right %0d",
                 edges_l, edges_r);
        error_count++;
    end
    finish_test("transition_spacing", errs);
endtask

// File: bench/tb_snd_dac.sv
// ============================================================
// Stereo, signed input, DIV=4; each density run starts from reset
// Runtime is bounded by a cycle counter, not by the test sequence
// ============================================================
`timescale 1ns/1ps

module tb_snd_dac;

    localparam int DIV      = 4;
    localparam int RST_CYC  = 10;
    localparam int SETTLE   = 256;
    localparam int MEASURE  = 4096;
    localparam int MAX_RUN  = 4;
    localparam int SPAN_CYC = 512;
    localparam int NUM_RUNS = 12;

    // One density run is a reset, a settling window and a counted window
    localparam int RUN_CYC   = RST_CYC + (SETTLE + MEASURE) * DIV;
    localparam int TOTAL_CYC = NUM_RUNS * RUN_CYC + 3 * RST_CYC + 17 * DIV + SPAN_CYC;
    localparam int LIMIT_CYC = TOTAL_CYC * 3 / 2;

    // Allowed density error
    localparam real TOL = 1.0 / 128.0;

    logic          clk_dac;
    logic          rst;
    snd_pkg::pcm_t snd_left;
    snd_pkg::pcm_t snd_right;
    logic          pwm_left;
    logic          pwm_right;

    int          error_count;
    int          test_count;
    int          failed_tests;
    int          cycle_count;
    logic [31:0] lcg_state;

    snd_dac_top #(
        .SIGNED_SND      ( 1'b1      ),
        .STEREO          ( 1'b1      ),
        .DIV             ( DIV       )
    ) dut_i (
        .clk_dac         ( clk_dac   ),
        .rst             ( rst       ),
        .snd_left_i      ( snd_left  ),
        .snd_right_i     ( snd_right ),
        .snd_pwm_left_o  ( pwm_left  ),
        .snd_pwm_right_o ( pwm_right )
    );

    always #5 clk_dac = ~clk_dac;

    // Hard stop if a test never returns
    always @(posedge clk_dac) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= LIMIT_CYC) begin
            $display("Timeout: run did not finish within %0d clock cycles", LIMIT_CYC);
            $display("Simulation failed");
            $finish;
        end
    end

    `include "tb_snd_tasks.svh"

    initial begin
        clk_dac      = 1'b0;
        rst          = 1'b1;
        snd_left     = '0;
        snd_right    = '0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        lcg_state    = 32'd53491;

        repeat (RST_CYC) @(posedge clk_dac);
        #1;
        rst = 1'b0;

        test_reset_low();
        test_extremes();
        test_midscale();
        test_random_levels();
        test_stereo();
        test_transition_spacing();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+bench
rtl/snd_pkg.sv
rtl/snd_cen_gen.sv
rtl/snd_pcm_cond.sv
rtl/snd_sigma_delta.sv
rtl/snd_dac_top.sv
bench/tb_snd_dac.sv

// File: run.sh
#!/bin/sh
# Builds and runs the audio DAC testbench with Verilator.
# Exit status is zero only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

TOP=tb_snd_dac
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    -Mdir "$BUILD_DIR" \
    --top-module "$TOP" \
    -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP" 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    echo "No pass report found in the simulation output"
    exit 1
fi
